//--- core_params.svh
/*
 * Core-wide sizing macros. Only a 32-bit datapath with 32 registers is
 * supported by the decoder and immediate logic
 */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Data and address width
`define CORE_XLEN 32

// Architectural integer registers, x0 included
`define CORE_NREGS 32

`endif

//--- logic/core_pkg.sv
/*
 * Types shared by the pipeline stages. Register indices are sized from
 * CORE_NREGS, so it must stay a power of two
 */
`include "core_params.svh"

package core_pkg;

    // Major opcodes handled by the decoder
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef logic [$clog2(`CORE_NREGS)-1:0] reg_addr_t;
    typedef logic [`CORE_XLEN-1:0] word_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_type_t;

    // Branch immediate is scattered across the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    typedef union packed {
        r_type_t r_view;
        i_type_t i_view;
        b_type_t b_view;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_NONE
    } alu_op_e;

    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_u instr;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      we;
        alu_op_e   alu_op;
        logic      use_imm;
        word_t     imm;
        logic      is_beq;
    } id_rr_t;

    typedef struct packed {
        id_rr_t instr;
        word_t  rs1_data;
        word_t  rs2_data;
    } rr_exe_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        logic      we;
        word_t     result;
    } exe_wb_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } wb_bypass_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        logic      we;
        word_t     data;
    } commit_t;

endpackage

//--- logic/fetch_stage.sv
/*
 * PC sequencing only. The instruction port must answer in the same cycle
 * as pc_o; a redirect takes priority over a stall
 */
`timescale 1ns/1ps
`include "core_params.svh"

module fetch_stage (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic [`CORE_XLEN-1:0] reset_addr_i,
    input  logic                  stall_i,
    input  core_pkg::redirect_t   redirect_i,
    input  core_pkg::instr_u      instr_i,
    output logic [`CORE_XLEN-1:0] pc_o,
    output core_pkg::if_id_t      fetch_o
);

    logic [`CORE_XLEN-1:0] pc_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= reset_addr_i;
        end else if (redirect_i.valid) begin
            pc_q <= redirect_i.target;
        end else if (!stall_i) begin
            pc_q <= pc_q + `CORE_XLEN'(4);
        end
    end

    assign pc_o = pc_q;

    // A stalled fetch hands a bubble to decode
    assign fetch_o.valid = !stall_i;
    assign fetch_o.pc    = pc_q;
    assign fetch_o.instr = instr_i;

endmodule

//--- logic/decoder.sv
/*
 * Decodes ADD, SUB, AND, OR, XOR, ADDI and BEQ. Anything else, including
 * other funct3 or funct7 encodings, leaves as a bubble
 */
`timescale 1ns/1ps

module decoder (
    input  core_pkg::if_id_t decode_i,
    output core_pkg::id_rr_t decode_o
);

    core_pkg::instr_u instr;
    logic             supported;
    logic             writes_rd;

    assign instr = decode_i.instr;

    always_comb begin
        supported        = 1'b0;
        writes_rd        = 1'b0;
        decode_o         = '0;
        decode_o.pc      = decode_i.pc;
        decode_o.rs1     = instr.r_view.rs1;
        decode_o.rs2     = instr.r_view.rs2;
        decode_o.rd      = instr.r_view.rd;
        decode_o.alu_op  = core_pkg::ALU_PASS_NONE;

        case (instr.r_view.opcode)
            core_pkg::OPC_OP: begin
                supported = 1'b1;
                writes_rd = 1'b1;
                case ({instr.r_view.funct7, instr.r_view.funct3})
                    {7'h00, 3'b000}: decode_o.alu_op = core_pkg::ALU_ADD;
                    {7'h20, 3'b000}: decode_o.alu_op = core_pkg::ALU_SUB;
                    {7'h00, 3'b100}: decode_o.alu_op = core_pkg::ALU_XOR;
                    {7'h00, 3'b110}: decode_o.alu_op = core_pkg::ALU_OR;
                    {7'h00, 3'b111}: decode_o.alu_op = core_pkg::ALU_AND;
                    default:         supported = 1'b0;
                endcase
            end
            core_pkg::OPC_OP_IMM: begin
                // Only ADDI in this core
                supported        = (instr.i_view.funct3 == 3'b000);
                writes_rd        = 1'b1;
                decode_o.alu_op  = core_pkg::ALU_ADD;
                decode_o.use_imm = 1'b1;
                decode_o.imm     = {{20{instr.i_view.imm12[11]}}, instr.i_view.imm12};
            end
            core_pkg::OPC_BRANCH: begin
                supported       = (instr.b_view.funct3 == 3'b000);
                decode_o.is_beq = 1'b1;
                // Bits that would be rd belong to the immediate here
                decode_o.rd     = '0;
                decode_o.imm    = {{19{instr.b_view.imm12}}, instr.b_view.imm12,
                                   instr.b_view.imm11, instr.b_view.imm10_5,
                                   instr.b_view.imm4_1, 1'b0};
            end
            default: begin
                supported = 1'b0;
            end
        endcase

        // x0 as destination retires without a write
        decode_o.we    = writes_rd && (decode_o.rd != '0);
        decode_o.valid = decode_i.valid && supported;
    end

endmodule

//--- logic/regfile.sv
/*
 * Two asynchronous read ports, one write port. A read of the register
 * written in the same cycle returns the incoming data
 */
`timescale 1ns/1ps
`include "core_params.svh"

module regfile (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic                            we_i,
    input  logic [$clog2(`CORE_NREGS)-1:0]  waddr_i,
    input  logic [`CORE_XLEN-1:0]           wdata_i,
    input  logic [$clog2(`CORE_NREGS)-1:0]  raddr1_i,
    input  logic [$clog2(`CORE_NREGS)-1:0]  raddr2_i,
    output logic [`CORE_XLEN-1:0]           rdata1_o,
    output logic [`CORE_XLEN-1:0]           rdata2_o
);

    logic [`CORE_XLEN-1:0] regs_q [`CORE_NREGS];
    logic                  wr_en;

    // x0 is never written, so it reads zero forever
    assign wr_en = we_i && (waddr_i != '0);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Write-through covers the write-back to register-read distance
    assign rdata1_o = (wr_en && waddr_i == raddr1_i) ? wdata_i : regs_q[raddr1_i];
    assign rdata2_o = (wr_en && waddr_i == raddr2_i) ? wdata_i : regs_q[raddr2_i];

endmodule

//--- logic/exe_stage.sv
/*
 * Purely combinational execute. Only the write-back stage is bypassed;
 * older results must come through the register file
 */
`timescale 1ns/1ps
`include "core_params.svh"

module exe_stage (
    input  core_pkg::rr_exe_t    from_rr_i,
    input  core_pkg::wb_bypass_t bypass_i,
    output core_pkg::exe_wb_t    to_wb_o,
    output core_pkg::redirect_t  redirect_o
);

    core_pkg::id_rr_t      instr;
    logic                  fwd_a;
    logic                  fwd_b;
    logic [`CORE_XLEN-1:0] op_a;
    logic [`CORE_XLEN-1:0] op_b;
    logic [`CORE_XLEN-1:0] alu_b;
    logic [`CORE_XLEN-1:0] result;

    assign instr = from_rr_i.instr;

    // Bypass from write-back, never for x0
    assign fwd_a = bypass_i.valid && (bypass_i.rd != '0) && (bypass_i.rd == instr.rs1);
    assign fwd_b = bypass_i.valid && (bypass_i.rd != '0) && (bypass_i.rd == instr.rs2);

    assign op_a  = fwd_a ? bypass_i.data : from_rr_i.rs1_data;
    assign op_b  = fwd_b ? bypass_i.data : from_rr_i.rs2_data;
    assign alu_b = instr.use_imm ? instr.imm : op_b;

    always_comb begin
        case (instr.alu_op)
            core_pkg::ALU_ADD: result = op_a + alu_b;
            core_pkg::ALU_SUB: result = op_a - alu_b;
            core_pkg::ALU_AND: result = op_a & alu_b;
            core_pkg::ALU_OR:  result = op_a | alu_b;
            core_pkg::ALU_XOR: result = op_a ^ alu_b;
            default:           result = '0;
        endcase
    end

    assign to_wb_o.valid  = instr.valid;
    assign to_wb_o.pc     = instr.pc;
    assign to_wb_o.rd     = instr.rd;
    assign to_wb_o.we     = instr.we && !instr.is_beq;
    assign to_wb_o.result = result;

    // BEQ resolves here, target is pc-relative
    assign redirect_o.valid  = instr.valid && instr.is_beq && (op_a == op_b);
    assign redirect_o.target = instr.pc + instr.imm;

endmodule

//--- logic/datapath.sv
/*
 * Five-stage in-order RV32I subset. No back-pressure on commit_o and no
 * hazard stalls: write-back bypass plus write-through cover all distances
 */
`timescale 1ns/1ps
`include "core_params.svh"

module datapath (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic [`CORE_XLEN-1:0] reset_addr_i,
    input  logic                  halt_i,
    input  core_pkg::instr_u      instr_i,
    output logic [`CORE_XLEN-1:0] instr_pc_o,
    output core_pkg::commit_t     commit_o
);

    core_pkg::if_id_t     stage_if_id_d;
    core_pkg::if_id_t     stage_if_id_q;
    core_pkg::id_rr_t     stage_id_rr_d;
    core_pkg::id_rr_t     stage_id_rr_q;
    core_pkg::rr_exe_t    stage_rr_exe_d;
    core_pkg::rr_exe_t    stage_rr_exe_q;
    core_pkg::exe_wb_t    stage_exe_wb_d;
    core_pkg::exe_wb_t    stage_exe_wb_q;

    core_pkg::redirect_t  redirect_exe;
    core_pkg::wb_bypass_t bypass_wb;
    logic                 flush;
    logic                 wb_we;

    // Taken branch kills everything younger than execute
    assign flush = redirect_exe.valid;

    fetch_stage u_fetch_stage (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .reset_addr_i (reset_addr_i),
        .stall_i      (halt_i),
        .redirect_i   (redirect_exe),
        .instr_i      (instr_i),
        .pc_o         (instr_pc_o),
        .fetch_o      (stage_if_id_d)
    );

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            stage_if_id_q <= '0;
        end else begin
            stage_if_id_q       <= stage_if_id_d;
            stage_if_id_q.valid <= stage_if_id_d.valid && !flush;
        end
    end

    decoder u_decoder (
        .decode_i (stage_if_id_q),
        .decode_o (stage_id_rr_d)
    );

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            stage_id_rr_q <= '0;
        end else begin
            stage_id_rr_q       <= stage_id_rr_d;
            stage_id_rr_q.valid <= stage_id_rr_d.valid && !flush;
        end
    end

    regfile u_regfile (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .we_i     (wb_we),
        .waddr_i  (stage_exe_wb_q.rd),
        .wdata_i  (stage_exe_wb_q.result),
        .raddr1_i (stage_id_rr_q.rs1),
        .raddr2_i (stage_id_rr_q.rs2),
        .rdata1_o (stage_rr_exe_d.rs1_data),
        .rdata2_o (stage_rr_exe_d.rs2_data)
    );

    assign stage_rr_exe_d.instr = stage_id_rr_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            stage_rr_exe_q <= '0;
        end else begin
            stage_rr_exe_q             <= stage_rr_exe_d;
            stage_rr_exe_q.instr.valid <= stage_rr_exe_d.instr.valid && !flush;
        end
    end

    exe_stage u_exe_stage (
        .from_rr_i  (stage_rr_exe_q),
        .bypass_i   (bypass_wb),
        .to_wb_o    (stage_exe_wb_d),
        .redirect_o (redirect_exe)
    );

    // The branch itself always reaches write-back
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            stage_exe_wb_q <= '0;
        end else begin
            stage_exe_wb_q <= stage_exe_wb_d;
        end
    end

    // Write-back
    assign wb_we = stage_exe_wb_q.valid && stage_exe_wb_q.we;

    assign bypass_wb.valid = wb_we;
    assign bypass_wb.rd    = stage_exe_wb_q.rd;
    assign bypass_wb.data  = stage_exe_wb_q.result;

    assign commit_o.valid = stage_exe_wb_q.valid;
    assign commit_o.pc    = stage_exe_wb_q.pc;
    assign commit_o.rd    = stage_exe_wb_q.rd;
    assign commit_o.we    = wb_we;
    assign commit_o.data  = stage_exe_wb_q.result;

endmodule

//--- verif/datapath_asserts.sv
/*
 * Protocol checks bound into datapath. The branch shadow check expects every
 * taken branch target to hold a supported instruction
 */
`timescale 1ns/1ps

module datapath_asserts (
    input logic                clk_i,
    input logic                rstn_i,
    input logic                halt_i,
    input logic                rr_valid_i,
    input core_pkg::redirect_t redirect_i,
    input core_pkg::commit_t   commit_i
);

    // Read by the testbench to end the run
    logic violation_seen = 1'b0;

    a_quiet_in_reset: assert property (@(posedge clk_i) !rstn_i |-> !commit_i.valid)
        else begin
            $error("commit_o.valid raised while reset is asserted");
            violation_seen = 1'b1;
        end

    // First fetch needs four more edges to reach write-back
    a_quiet_after_reset: assert property (@(posedge clk_i)
        $rose(rstn_i) |-> !commit_i.valid ##1 !commit_i.valid ##1 !commit_i.valid
                          ##1 !commit_i.valid)
        else begin
            $error("commit_o.valid raised within 4 cycles of reset release");
            violation_seen = 1'b1;
        end

    a_redirect_from_exe: assert property (@(posedge clk_i) disable iff (!rstn_i)
        redirect_i.valid |-> rr_valid_i)
        else begin
            $error("redirect valid while the execute stage holds a bubble");
            violation_seen = 1'b1;
        end

    a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rstn_i)
        commit_i.valid && commit_i.we |-> commit_i.rd != '0)
        else begin
            $error("commit reports a write to x0");
            violation_seen = 1'b1;
        end

    // Branch retires, three flushed slots, then the target unless fetch was halted
    a_branch_shadow: assert property (@(posedge clk_i) disable iff (!rstn_i)
        redirect_i.valid |=> commit_i.valid ##1 !commit_i.valid ##1 !commit_i.valid
                             ##1 !commit_i.valid ##1 (commit_i.valid || $past(halt_i, 4)))
        else begin
            $error("commit pattern after a taken branch is wrong");
            violation_seen = 1'b1;
        end

endmodule

//--- verif/datapath_tb.sv
/*
 * Runs a fixed program from a ROM at 0x1000 and checks each commit against
 * an ISA model. The program path may only hold supported instructions
 */
`timescale 1ns/1ps
`include "core_params.svh"

module datapath_tb;

    localparam logic [`CORE_XLEN-1:0] RESET_ADDR = 32'h0000_1000;
    localparam logic [`CORE_XLEN-1:0] LOOP_PC    = RESET_ADDR + 32'd68;
    localparam int                    ROM_WORDS  = 32;
    localparam int                    TIMEOUT_CYCLES = 2000;

    logic                  clk_i  = 1'b0;
    logic                  rstn_i = 1'b1;
    logic                  halt_i = 1'b0;
    logic [`CORE_XLEN-1:0] reset_addr_i;
    core_pkg::instr_u      instr_i;
    logic [`CORE_XLEN-1:0] instr_pc_o;
    core_pkg::commit_t     commit_o;

    logic [31:0] rom [ROM_WORDS];
    integer      seed = 32'hc5e0_f593;

    // ISA model state and the expected result of the next commit
    logic [31:0] model_pc;
    logic [31:0] model_regs [`CORE_NREGS];
    int          loop_commits;
    logic [31:0] model_word;
    logic [31:0] src_a;
    logic [31:0] src_b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [4:0]  exp_rd;
    logic        exp_we;
    logic [31:0] exp_data;
    logic [31:0] next_pc;

    datapath u_datapath (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .reset_addr_i (reset_addr_i),
        .halt_i       (halt_i),
        .instr_i      (instr_i),
        .instr_pc_o   (instr_pc_o),
        .commit_o     (commit_o)
    );

    bind datapath datapath_asserts u_datapath_asserts (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .halt_i     (halt_i),
        .rr_valid_i (stage_rr_exe_q.instr.valid),
        .redirect_i (redirect_exe),
        .commit_i   (commit_o)
    );

    always #5 clk_i = ~clk_i;

    assign reset_addr_i = RESET_ADDR;

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] itype_word(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] btype_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                               input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    // Outside the ROM reads as opcode zero, which decodes as a bubble
    function automatic logic [31:0] rom_word(input logic [31:0] pc);
        logic [31:0] offset;
        offset = pc - RESET_ADDR;
        if (offset < 32'(ROM_WORDS * 4)) begin
            return rom[offset[6:2]];
        end
        return 32'h0;
    endfunction

    task automatic load_program;
        // Unused words carry their own index over an unsupported opcode
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = {i[24:0], 7'h00};
        end
        rom[0]  = itype_word(5'd1, 5'd0, 12'd5);
        rom[1]  = itype_word(5'd2, 5'd1, 12'd3);
        rom[2]  = itype_word(5'd3, 5'd0, 12'hff9);
        // x2 at distance 2, x1 at distance 3
        rom[3]  = rtype_word(7'h00, 3'b000, 5'd4, 5'd1, 5'd2);
        rom[4]  = rtype_word(7'h20, 3'b000, 5'd5, 5'd4, 5'd3);
        rom[5]  = rtype_word(7'h00, 3'b100, 5'd6, 5'd5, 5'd2);
        rom[6]  = rtype_word(7'h00, 3'b110, 5'd7, 5'd4, 5'd6);
        rom[7]  = rtype_word(7'h00, 3'b111, 5'd8, 5'd7, 5'd5);
        rom[8]  = itype_word(5'd0, 5'd1, 12'd77);
        rom[9]  = rtype_word(7'h00, 3'b000, 5'd9, 5'd0, 5'd1);
        // Taken, skips the two wrong-path ADDIs
        rom[10] = btype_word(5'd8, 5'd5, 13'd12);
        rom[11] = itype_word(5'd10, 5'd0, 12'd111);
        rom[12] = itype_word(5'd11, 5'd0, 12'd222);
        rom[13] = itype_word(5'd12, 5'd9, 12'd1);
        rom[14] = btype_word(5'd12, 5'd9, 13'd8);
        rom[15] = rtype_word(7'h20, 3'b000, 5'd13, 5'd12, 5'd9);
        rom[16] = rtype_word(7'h00, 3'b000, 5'd14, 5'd13, 5'd0);
        rom[17] = btype_word(5'd0, 5'd0, 13'd0);
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic show_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        fail_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
    endtask

    always_comb begin
        instr_i = rom_word(instr_pc_o);
    end

    always_comb begin
        model_word = rom_word(model_pc);
        src_a      = model_regs[model_word[19:15]];
        src_b      = model_regs[model_word[24:20]];
        imm_i      = {{20{model_word[31]}}, model_word[31:20]};
        imm_b      = {{20{model_word[31]}}, model_word[7], model_word[30:25],
                      model_word[11:8], 1'b0};
        exp_rd     = model_word[11:7];
        exp_we     = 1'b0;
        exp_data   = '0;
        next_pc    = model_pc + 32'd4;
        case (model_word[6:0])
            7'b0110011: begin
                exp_we = (exp_rd != 5'd0);
                case ({model_word[31:25], model_word[14:12]})
                    {7'h00, 3'b000}: exp_data = src_a + src_b;
                    {7'h20, 3'b000}: exp_data = src_a - src_b;
                    {7'h00, 3'b100}: exp_data = src_a ^ src_b;
                    {7'h00, 3'b110}: exp_data = src_a | src_b;
                    {7'h00, 3'b111}: exp_data = src_a & src_b;
                    default:         exp_data = '0;
                endcase
            end
            7'b0010011: begin
                exp_we   = (exp_rd != 5'd0);
                exp_data = src_a + imm_i;
            end
            7'b1100011: begin
                if (src_a == src_b) begin
                    next_pc = model_pc + imm_b;
                end
            end
            default: begin
                exp_we = 1'b0;
            end
        endcase
    end

    // Model retires one instruction per observed commit
    always @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            model_pc     <= RESET_ADDR;
            loop_commits <= 0;
            for (int i = 0; i < `CORE_NREGS; i++) begin
                model_regs[i] <= '0;
            end
        end else if (commit_o.valid) begin
            model_pc <= next_pc;
            if (exp_we) begin
                model_regs[exp_rd] <= exp_data;
            end
            if (model_pc == LOOP_PC) begin
                loop_commits <= loop_commits + 1;
            end
        end
    end

    a_commit_pc: assert property (@(posedge clk_i) disable iff (!rstn_i)
        commit_o.valid |-> commit_o.pc == model_pc)
        else show_mismatch("commit_pc", $sampled(model_pc), $sampled(commit_o.pc));

    a_commit_we: assert property (@(posedge clk_i) disable iff (!rstn_i)
        commit_o.valid |-> commit_o.we == exp_we)
        else show_mismatch("commit_we", 32'($sampled(exp_we)), 32'($sampled(commit_o.we)));

    a_commit_rd: assert property (@(posedge clk_i) disable iff (!rstn_i)
        commit_o.valid && exp_we |-> commit_o.rd == exp_rd)
        else show_mismatch("commit_rd", 32'($sampled(exp_rd)), 32'($sampled(commit_o.rd)));

    a_commit_data: assert property (@(posedge clk_i) disable iff (!rstn_i)
        commit_o.valid && exp_we |-> commit_o.data == exp_data)
        else show_mismatch("commit_data", $sampled(exp_data), $sampled(commit_o.data));

    // Roughly one halt cycle in four
    always @(posedge clk_i) begin
        #1;
        halt_i = (($random(seed) & 32'd3) == 32'd0);
    end

    always @(negedge clk_i) begin
        if (u_datapath.u_datapath_asserts.violation_seen) begin
            fail_run("a protocol assertion bound to datapath failed");
        end
    end

    initial begin
        int cycles;
        load_program();
        #1;
        rstn_i = 1'b0;
        repeat (8) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        cycles = 0;
        while (!commit_o.valid && cycles < 50) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        if (!commit_o.valid) begin
            fail_run("no instruction committed after reset release");
        end

        // Two loop commits also let the loop's branch shadow check finish
        cycles = 0;
        while (loop_commits < 2 && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        if (loop_commits >= 2) begin
            $display("sim passed");
            $finish;
        end else begin
            fail_run("timeout waiting for the final self-loop branch to commit");
        end
    end

endmodule

//--- all.f
+incdir+.
logic/core_pkg.sv
logic/fetch_stage.sv
logic/decoder.sv
logic/regfile.sv
logic/exe_stage.sv
logic/datapath.sv
verif/datapath_asserts.sv
verif/datapath_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it, exit status reflects the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module datapath_tb -f all.f -o datapath_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past an assertion error so the testbench can report it
sim_out=$(./obj_dir/datapath_sim +verilator+error+limit+100)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "sim passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
